// File: design/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;
    import cache_cfg_pkg::*;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    // main controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS,       // dirty victim going out
        ST_REPLACE,    // line read requested
        ST_REFILL      // collecting return beats
    } cache_state_e;

    // one cpu request as accepted on addr_ok
    typedef struct packed {
        cache_op_e             op;
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [OFFSET_W-1:0]   offset;
        logic [STRB_W-1:0]     wstrb;
        logic [WORD_W-1:0]     wdata;
    } cpu_req_t;

    // what a way returns one cycle after the index
    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [TAG_W-1:0]      tag;
        logic [LINE_W-1:0]     line;   // word 0 in the low bits
    } way_rd_t;

    // write command into a way
    typedef struct packed {
        logic [WORDS-1:0]      word_we;
        logic [STRB_W-1:0]     word_wstrb;
        logic [WORD_W-1:0]     wdata;
        logic                  line_tag_we;   // new tag, set valid
        logic [TAG_W-1:0]      new_tag;
        logic                  set_dirty;
        logic                  clr_dirty;
    } way_wr_t;

endpackage

`default_nettype wire

// File: design/cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

    // address split: tag | index | offset
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;
    localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;   // full byte address

    // geometry
    localparam int SETS  = 1 << INDEX_W;   // 256 sets
    localparam int WAYS  = 2;
    localparam int WORDS = 4;              // words per line

    // word and line sizes
    localparam int WORD_W = 32;
    localparam int STRB_W = WORD_W / 8;    // one strobe per byte
    localparam int LINE_W = WORDS * WORD_W;

    // the offset splits into a word select and a byte offset
    localparam int WORD_SEL_W = $clog2(WORDS);
    localparam int BYTE_OFF_W = OFFSET_W - WORD_SEL_W;

endpackage

`default_nettype wire

// File: design/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import cache_cfg_pkg::*, cache_bus_pkg::*;
(
    input  wire                 clk,
    input  wire                 resetn,
    input  wire                 valid,
    input  wire cpu_req_t       req,
    input  wire way_rd_t        way0,
    input  wire way_rd_t        way1,
    input  wire                 rd_rdy,
    input  wire                 ret_valid,
    input  wire                 ret_last,
    input  wire [WORD_W-1:0]    ret_data,
    input  wire                 wr_rdy,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [WORD_W-1:0]   rdata,
    output logic [INDEX_W-1:0]  way_index,
    output way_wr_t             way0_wr,
    output way_wr_t             way1_wr,
    output logic                rd_req,
    output logic [ADDR_W-1:0]   rd_addr,
    output logic                wr_req,
    output logic [ADDR_W-1:0]   wr_addr,
    output logic [LINE_W-1:0]   wr_data
);

    cache_state_e          state;
    cache_state_e          state_nxt;
    cpu_req_t              req_q;
    logic [SETS-1:0]       lru;        // per set, next way to evict
    logic [WAYS-1:0]       hit_vec;
    logic                  hit;
    logic [WORD_SEL_W-1:0] word_sel;
    logic [WORD_SEL_W-1:0] beat_cnt;
    logic [LINE_W-1:0]     hit_line;
    logic [WORD_W-1:0]     hit_word;
    logic                  victim;
    way_rd_t               victim_rd;
    logic                  victim_q;
    logic [TAG_W-1:0]      victim_tag_q;
    logic [LINE_W-1:0]     victim_line_q;
    logic [WORD_W-1:0]     rword_q;    // requested word seen during refill
    logic                  refill_beat;
    logic                  refill_done;
    way_wr_t               wr_cmd;
    logic                  wr_way;

    function automatic logic [WORD_W-1:0] merge_bytes(
        input logic [WORD_W-1:0] old_word,
        input logic [WORD_W-1:0] new_word,
        input logic [STRB_W-1:0] strb
    );
        logic [WORD_W-1:0] res;
        res = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign word_sel   = req_q.offset[OFFSET_W-1:BYTE_OFF_W];
    assign hit_vec[0] = way0.valid && (way0.tag == req_q.tag);
    assign hit_vec[1] = way1.valid && (way1.tag == req_q.tag);
    assign hit        = |hit_vec;
    assign hit_line   = hit_vec[1] ? way1.line : way0.line;
    assign hit_word   = hit_line[word_sel*WORD_W +: WORD_W];

    // empty way first, otherwise lru
    always_comb begin
        if (!way0.valid) begin
            victim = 1'b0;
        end else if (!way1.valid) begin
            victim = 1'b1;
        end else begin
            victim = lru[req_q.index];
        end
    end
    assign victim_rd = victim ? way1 : way0;

    assign refill_beat = (state == ST_REFILL) && ret_valid;
    assign refill_done = refill_beat && ret_last;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (valid) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    state_nxt = ST_IDLE;
                end else if (victim_rd.valid && victim_rd.dirty) begin
                    state_nxt = ST_MISS;
                end else begin
                    state_nxt = ST_REPLACE;
                end
            end
            ST_MISS:    if (wr_rdy) state_nxt = ST_REPLACE;
            ST_REPLACE: if (rd_rdy) state_nxt = ST_REFILL;
            ST_REFILL:  if (refill_done) state_nxt = ST_IDLE;
            default:    state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
            lru      <= '0;
        end else begin
            state <= state_nxt;
            if (refill_beat) begin
                beat_cnt <= ret_last ? '0 : beat_cnt + 1'b1;
            end
            if (state == ST_LOOKUP && hit) begin
                lru[req_q.index] <= ~hit_vec[1];   // other way goes next
            end else if (refill_done) begin
                lru[req_q.index] <= ~victim_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && valid) begin
            req_q <= req;
        end
        if (state == ST_LOOKUP) begin
            victim_q      <= victim;
            victim_tag_q  <= victim_rd.tag;
            victim_line_q <= victim_rd.line;
        end
        if (refill_beat && beat_cnt == word_sel) begin
            rword_q <= ret_data;
        end
    end

    // write hit in lookup, or one refill beat
    always_comb begin
        wr_cmd = '0;
        wr_way = victim_q;
        if (state == ST_LOOKUP && hit && req_q.op == OP_WRITE) begin
            wr_way                   = hit_vec[1];
            wr_cmd.word_we[word_sel] = 1'b1;
            wr_cmd.word_wstrb        = req_q.wstrb;
            wr_cmd.wdata             = req_q.wdata;
            wr_cmd.set_dirty         = 1'b1;
        end else if (refill_beat) begin
            wr_cmd.word_we[beat_cnt] = 1'b1;
            wr_cmd.word_wstrb        = '1;
            if (req_q.op == OP_WRITE && beat_cnt == word_sel) begin
                wr_cmd.wdata = merge_bytes(ret_data, req_q.wdata, req_q.wstrb);
            end else begin
                wr_cmd.wdata = ret_data;
            end
            wr_cmd.line_tag_we = ret_last;
            wr_cmd.new_tag     = req_q.tag;
            wr_cmd.set_dirty   = ret_last && (req_q.op == OP_WRITE);
            wr_cmd.clr_dirty   = ret_last && (req_q.op == OP_READ);
        end
    end

    always_comb begin
        way0_wr = wr_cmd;
        way1_wr = wr_cmd;
        if (wr_way) begin
            way0_wr = '0;
        end else begin
            way1_wr = '0;
        end
    end

    assign addr_ok   = (state == ST_IDLE);
    assign data_ok   = (state == ST_LOOKUP && hit) || refill_done;
    assign way_index = (state == ST_IDLE) ? req.index : req_q.index;

    // last beat may itself carry the requested word
    assign rdata = (state != ST_REFILL) ? hit_word :
                   (beat_cnt == word_sel) ? ret_data : rword_q;

    assign rd_req  = (state == ST_REPLACE);
    assign rd_addr = {req_q.tag, req_q.index, {OFFSET_W{1'b0}}};
    assign wr_req  = (state == ST_MISS);
    assign wr_addr = {victim_tag_q, req_q.index, {OFFSET_W{1'b0}}};
    assign wr_data = victim_line_q;

endmodule

`default_nettype wire

// File: design/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top
    import cache_cfg_pkg::*, cache_bus_pkg::*;
(
    input  wire                 clk,
    input  wire                 resetn,
    // cpu side
    input  wire                 valid,
    input  wire                 op,        // 1 write, 0 read
    input  wire [INDEX_W-1:0]   index,
    input  wire [TAG_W-1:0]     tag,
    input  wire [OFFSET_W-1:0]  offset,
    input  wire [STRB_W-1:0]    wstrb,
    input  wire [WORD_W-1:0]    wdata,
    output wire                 addr_ok,
    output wire                 data_ok,
    output wire [WORD_W-1:0]    rdata,
    // memory side
    output wire                 rd_req,
    output wire [ADDR_W-1:0]    rd_addr,
    input  wire                 rd_rdy,
    input  wire                 ret_valid,
    input  wire                 ret_last,
    input  wire [WORD_W-1:0]    ret_data,
    output wire                 wr_req,
    output wire [ADDR_W-1:0]    wr_addr,
    output wire [LINE_W-1:0]    wr_data,
    input  wire                 wr_rdy
);

    cpu_req_t           cpu_req;
    logic [INDEX_W-1:0] way_index;
    way_rd_t            way0_rd;
    way_rd_t            way1_rd;
    way_wr_t            way0_wr;
    way_wr_t            way1_wr;

    assign cpu_req = '{
        op:     cache_op_e'(op),
        tag:    tag,
        index:  index,
        offset: offset,
        wstrb:  wstrb,
        wdata:  wdata
    };

    cache_way way0_inst (
        .clk    (clk),
        .resetn (resetn),
        .index  (way_index),
        .wr     (way0_wr),
        .rd     (way0_rd)
    );

    cache_way way1_inst (
        .clk    (clk),
        .resetn (resetn),
        .index  (way_index),
        .wr     (way1_wr),
        .rd     (way1_rd)
    );

    cache_ctrl ctrl_inst (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .req       (cpu_req),
        .way0      (way0_rd),
        .way1      (way1_rd),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_rdy    (wr_rdy),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .way_index (way_index),
        .way0_wr   (way0_wr),
        .way1_wr   (way1_wr),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

endmodule

`default_nettype wire

// File: design/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way
    import cache_cfg_pkg::*, cache_bus_pkg::*;
(
    input  wire                clk,
    input  wire                resetn,
    input  wire [INDEX_W-1:0]  index,
    input  wire way_wr_t       wr,
    output way_rd_t            rd
);

    logic [TAG_W-1:0]  tag_mem  [SETS];
    logic [WORD_W-1:0] data_mem [SETS][WORDS];
    logic [SETS-1:0]   valid_bits;
    logic [SETS-1:0]   dirty_bits;

    // byte-strobed word writes, tag on line fill
    always_ff @(posedge clk) begin
        for (int w = 0; w < WORDS; w++) begin
            if (wr.word_we[w]) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (wr.word_wstrb[b]) begin
                        data_mem[index][w][b*8 +: 8] <= wr.wdata[b*8 +: 8];
                    end
                end
            end
        end
        if (wr.line_tag_we) begin
            tag_mem[index] <= wr.new_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (wr.line_tag_we) begin
                valid_bits[index] <= 1'b1;
            end
            if (wr.set_dirty) begin
                dirty_bits[index] <= 1'b1;
            end else if (wr.clr_dirty) begin
                dirty_bits[index] <= 1'b0;
            end
        end
    end

    // synchronous read, old contents on a same-set write
    always_ff @(posedge clk) begin
        rd.tag <= tag_mem[index];
        for (int w = 0; w < WORDS; w++) begin
            rd.line[w*WORD_W +: WORD_W] <= data_mem[index][w];
        end
        if (!resetn) begin
            rd.valid <= 1'b0;
            rd.dirty <= 1'b0;
        end else begin
            rd.valid <= valid_bits[index];
            rd.dirty <= dirty_bits[index];
        end
    end

endmodule

`default_nettype wire

// File: src.f
design/cache_cfg_pkg.sv
design/cache_bus_pkg.sv
design/cache_way.sv
design/cache_ctrl.sv
design/cache_top.sv
tb/tb_clock.sv
tb/cache_assert.sv
tb/cache_tb.sv

// File: tb/cache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cache_assert
    import cache_cfg_pkg::*, cache_bus_pkg::*;
(
    input wire                clk,
    input wire                resetn,
    input wire                addr_ok,
    input wire                data_ok,
    input wire                rd_req,
    input wire                rd_rdy,
    input wire [ADDR_W-1:0]   rd_addr,
    input wire                wr_req,
    input wire                wr_rdy,
    input wire [ADDR_W-1:0]   wr_addr,
    input wire [LINE_W-1:0]   wr_data,
    input wire way_wr_t       way0_wr,
    input wire way_wr_t       way1_wr,
    input wire cache_state_e  state
);

    int         fail_cnt = 0;   // failure tally, watched by the testbench
    logic       refill_wr;      // refill word going into either way
    logic [2:0] beats;          // refill words written in this refill

    assign refill_wr = (state == ST_REFILL) && (|way0_wr.word_we || |way1_wr.word_we);

    always_ff @(posedge clk) begin
        if (!resetn || state != ST_REFILL) begin
            beats <= '0;
        end else if (refill_wr) begin
            beats <= beats + 3'd1;
        end
    end

    no_dual_req: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
        else begin
            $error("rd_req and wr_req high in the same cycle");
            fail_cnt++;
        end

    rd_req_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            $error("rd_req dropped or rd_addr moved while stalled");
            fail_cnt++;
        end

    wr_req_hold: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else begin
            $error("wr_req dropped or write data moved while stalled");
            fail_cnt++;
        end

    ok_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(addr_ok && data_ok))
        else begin
            $error("addr_ok and data_ok high in the same cycle");
            fail_cnt++;
        end

    beat_limit: assert property (@(posedge clk) disable iff (!resetn)
        refill_wr |-> beats < 3'd4)
        else begin
            $error("more than four return beats in one refill");
            fail_cnt++;
        end

endmodule

bind cache_top cache_assert prot_check (
    .clk       (clk),
    .resetn    (resetn),
    .addr_ok   (addr_ok),
    .data_ok   (data_ok),
    .rd_req    (rd_req),
    .rd_rdy    (rd_rdy),
    .rd_addr   (rd_addr),
    .wr_req    (wr_req),
    .wr_rdy    (wr_rdy),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .way0_wr   (way0_wr),
    .way1_wr   (way1_wr),
    .state     (ctrl_inst.state)
);

`default_nettype wire

// File: tb/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb
    import cache_cfg_pkg::*, cache_bus_pkg::*;
;

    localparam logic [31:0] SEED = 32'h3f88_e519;
    localparam int RANDOM_REQS    = 600;
    localparam int MAX_REQ_CYCLES = 40;
    localparam int TIMEOUT_CYCLES = RANDOM_REQS * MAX_REQ_CYCLES + 1000;

    wire                 clk;
    logic                resetn;
    logic                valid;
    logic                op;
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] offset;
    logic [STRB_W-1:0]   wstrb;
    logic [WORD_W-1:0]   wdata;
    wire                 addr_ok;
    wire                 data_ok;
    wire [WORD_W-1:0]    rdata;
    wire                 rd_req;
    wire [ADDR_W-1:0]    rd_addr;
    logic                rd_rdy;
    logic                ret_valid;
    logic                ret_last;
    logic [WORD_W-1:0]   ret_data;
    wire                 wr_req;
    wire [ADDR_W-1:0]    wr_addr;
    wire [LINE_W-1:0]    wr_data;
    logic                wr_rdy;

    logic [WORD_W-1:0] mem    [logic [ADDR_W-1:0]];   // backing memory
    logic [WORD_W-1:0] shadow [logic [ADDR_W-1:0]];   // latest cpu view
    cpu_req_t          cur_req;
    logic              pending;
    logic [31:0]       stim_rng;
    logic [31:0]       mem_rng;
    int                wr_count;
    int                rd_count;
    int                cycle_cnt;
    logic [ADDR_W-1:0] last_wr_addr;

    tb_clock clk_gen (.clk(clk));

    cache_top UUT (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // fixed scramble of the full address
    function automatic logic [WORD_W-1:0] mem_init_word(input logic [ADDR_W-1:0] addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return mem_init_word(addr);
    endfunction

    function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return mem_init_word(addr);
    endfunction

    function automatic logic [LINE_W-1:0] shadow_line(input logic [ADDR_W-1:0] line_addr);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < WORDS; w++) begin
            line[w*WORD_W +: WORD_W] = expected_word(line_addr + 32'(w * 4));
        end
        return line;
    endfunction

    function automatic logic [ADDR_W-1:0] word_addr(input cpu_req_t r);
        return {r.tag, r.index, r.offset[OFFSET_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
    endfunction

    function automatic cpu_req_t make_req(
        input cache_op_e          op_sel,
        input logic [TAG_W-1:0]   tag_sel,
        input logic [INDEX_W-1:0] index_sel,
        input int                 word,
        input logic [STRB_W-1:0]  strb,
        input logic [WORD_W-1:0]  data
    );
        cpu_req_t r;
        r.op     = op_sel;
        r.tag    = tag_sel;
        r.index  = index_sel;
        r.offset = {word[WORD_SEL_W-1:0], {BYTE_OFF_W{1'b0}}};
        r.wstrb  = strb;
        r.wdata  = data;
        return r;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic update_shadow(input cpu_req_t r);
        logic [ADDR_W-1:0] a;
        logic [WORD_W-1:0] w;
        a = word_addr(r);
        w = expected_word(a);
        for (int b = 0; b < STRB_W; b++) begin
            if (r.wstrb[b]) begin
                w[b*8 +: 8] = r.wdata[b*8 +: 8];
            end
        end
        shadow[a] = w;
    endtask

    // one request, latency counted from the accepting edge
    task automatic issue_request(input cpu_req_t r, output int latency);
        @(negedge clk);
        valid   = 1'b1;
        op      = r.op;
        tag     = r.tag;
        index   = r.index;
        offset  = r.offset;
        wstrb   = r.wstrb;
        wdata   = r.wdata;
        cur_req = r;
        pending = 1'b1;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
        @(negedge clk);
        valid = 1'b0;
        if (r.op == OP_WRITE) begin
            update_shadow(r);
        end
        latency = 1;
        @(posedge clk);
        while (!data_ok) begin
            @(posedge clk);
            latency++;
        end
        @(negedge clk);
        pending = 1'b0;
    endtask

    always @(posedge clk) begin : compare_outputs
        if (resetn) begin
            assert (UUT.prot_check.fail_cnt == 0)
                else abort_run("a protocol assertion failed");
            if (data_ok) begin
                assert (pending) else abort_run("data_ok came with no request outstanding");
                if (cur_req.op == OP_READ) begin
                    assert (rdata === expected_word(word_addr(cur_req)))
                        else abort_run($sformatf("Error: %0t read of %h returned %h, expected %h",
                            $time, word_addr(cur_req), rdata,
                            expected_word(word_addr(cur_req))));
                end
            end
            if (wr_req && wr_rdy) begin
                assert (wr_data === shadow_line(wr_addr))
                    else abort_run($sformatf("Error: %0t write-back of %h carried %h, expected %h",
                        $time, wr_addr, wr_data, shadow_line(wr_addr)));
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // line memory, random stalls and beat gaps
    initial begin : memory_model
        int               gap;
        logic [ADDR_W-1:0] base;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_count  = 0;
        rd_count  = 0;
        last_wr_addr = '0;
        mem_rng   = lcg_step(SEED);
        forever begin
            @(negedge clk);
            if (resetn && wr_req) begin
                mem_rng = lcg_step(mem_rng);
                gap = mem_rng[31:30];
                repeat (gap) @(negedge clk);
                wr_rdy = 1'b1;
                @(posedge clk);
                for (int w = 0; w < WORDS; w++) begin
                    mem[wr_addr + 32'(w * 4)] = wr_data[w*WORD_W +: WORD_W];
                end
                last_wr_addr = wr_addr;
                wr_count++;
                @(negedge clk);
                wr_rdy = 1'b0;
            end else if (resetn && rd_req) begin
                mem_rng = lcg_step(mem_rng);
                gap = mem_rng[31:30];
                repeat (gap) @(negedge clk);
                rd_rdy = 1'b1;
                @(posedge clk);
                base = rd_addr;
                rd_count++;
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int w = 0; w < WORDS; w++) begin
                    mem_rng = lcg_step(mem_rng);
                    gap = mem_rng[31:30];
                    repeat (gap) begin
                        ret_valid = 1'b0;
                        @(negedge clk);
                    end
                    ret_valid = 1'b1;
                    ret_data  = mem_word(base + 32'(w * 4));
                    ret_last  = (w == WORDS - 1);
                    @(negedge clk);
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    initial begin : stimulus
        cpu_req_t r;
        int       lat;
        int       wr_before;
        int       rd_before;
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = 1'b0;
        index     = '0;
        tag       = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        pending   = 1'b0;
        cur_req   = '0;
        cycle_cnt = 0;
        stim_rng  = SEED;
        repeat (10) @(negedge clk);
        resetn = 1'b1;

        // cold read miss, then the same word hits
        wr_before = wr_count;
        rd_before = rd_count;
        issue_request(make_req(OP_READ, 20'h00abc, 8'h21, 2, '0, '0), lat);
        assert (wr_count == wr_before && rd_count == rd_before + 1)
            else abort_run("the first read of an unused set did not refill cleanly");
        issue_request(make_req(OP_READ, 20'h00abc, 8'h21, 2, '0, '0), lat);
        assert (lat == 1)
            else abort_run($sformatf("Error: %0t read hit took %0d cycles, expected 1", $time, lat));

        // partial write hit then read back
        issue_request(make_req(OP_WRITE, 20'h00abc, 8'h21, 2, 4'b0101, 32'hdead_beef), lat);
        assert (lat == 1)
            else abort_run($sformatf("Error: %0t write hit took %0d cycles, expected 1", $time, lat));
        issue_request(make_req(OP_READ, 20'h00abc, 8'h21, 2, '0, '0), lat);

        // three tags on one set evict the dirty lru line
        issue_request(make_req(OP_WRITE, 20'h11111, 8'h5a, 0, 4'hf, 32'h1111_aaaa), lat);
        issue_request(make_req(OP_WRITE, 20'h22222, 8'h5a, 1, 4'hf, 32'h2222_bbbb), lat);
        wr_before = wr_count;
        issue_request(make_req(OP_WRITE, 20'h33333, 8'h5a, 3, 4'b0011, 32'h3333_cccc), lat);
        assert (wr_count == wr_before + 1)
            else abort_run("the third tag did not evict exactly one line");
        assert (last_wr_addr == {20'h11111, 8'h5a, 4'h0})
            else abort_run($sformatf("Error: %0t evicted line %h, expected %h",
                $time, last_wr_addr, {20'h11111, 8'h5a, 4'h0}));
        issue_request(make_req(OP_READ, 20'h11111, 8'h5a, 0, '0, '0), lat);

        // write miss allocates and merges
        rd_before = rd_count;
        issue_request(make_req(OP_WRITE, 20'h0f0f0, 8'h77, 1, 4'b1100, 32'hcafe_f00d), lat);
        assert (rd_count == rd_before + 1)
            else abort_run("a write miss did not fetch its line");
        issue_request(make_req(OP_READ, 20'h0f0f0, 8'h77, 1, '0, '0), lat);
        assert (lat == 1)
            else abort_run($sformatf("Error: %0t allocated line missed, latency %0d", $time, lat));

        // random mix over four tags and two sets
        for (int i = 0; i < RANDOM_REQS; i++) begin
            stim_rng = lcg_step(stim_rng);
            r = make_req(cache_op_e'(stim_rng[31]), 20'h00100 + stim_rng[30:29],
                         8'h40 + stim_rng[28], stim_rng[27:26], stim_rng[25:22], '0);
            stim_rng = lcg_step(stim_rng);
            r.wdata  = stim_rng;
            issue_request(r, lat);
        end

        if (UUT.prot_check.fail_cnt == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run("a protocol assertion failed during the run");
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

endmodule

`default_nettype wire
